/* logic/dpb_adapter_pkg.sv */
package dpb_adapter_pkg;

  // Data and buffer geometry
  localparam int DATA_WIDTH = 32;
  localparam int MEM_DEPTH  = 9;

  // Words held by one ping-pong bank
  localparam int PP_DEPTH      = 16;
  localparam int PP_ADDR_WIDTH = $clog2(PP_DEPTH);

  // Stable-address cycles before user read data counts as settled
  localparam int MEM_WAIT   = 2;
  localparam int WAIT_WIDTH = $clog2(MEM_WAIT + 1);

  typedef logic [DATA_WIDTH-1:0]        word_t;
  typedef logic [MEM_DEPTH-1:0]         mem_addr_t;
  typedef logic [$clog2(PP_DEPTH+1)-1:0] pp_count_t;
  typedef logic [31:0]                  read_count_t;
  typedef logic [WAIT_WIDTH-1:0]        wait_count_t;

  // One request on either buffer port
  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    word_t     din;
  } bram_req_t;

  // Writer side of a ping-pong FIFO
  typedef struct packed {
    logic [1:0] activate;
    logic       stb;
    word_t      data;
  } pp_wr_req_t;

  // Reader side of a ping-pong FIFO
  typedef struct packed {
    logic activate;
    logic stb;
  } pp_rd_req_t;

  typedef struct packed {
    logic      ready;
    pp_count_t size;
    word_t     data;
  } pp_rd_rsp_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_DRAIN,
    SEQ_LOAD_SETUP,
    SEQ_LOAD
  } seq_state_t;

endpackage

/* logic/dual_port_buffer.sv */
`timescale 1ns/1ps

module dual_port_buffer
  import dpb_adapter_pkg::*;
(
  input  logic      clk,
  input  bram_req_t i_a_req,
  output word_t     o_a_dout,
  input  bram_req_t i_b_req,
  output word_t     o_b_dout
);

  word_t mem [0:(2**MEM_DEPTH)-1];

  // Port A, read-first
  always @(posedge clk) begin
    o_a_dout <= mem[i_a_req.addr];
    if (i_a_req.we) begin
      mem[i_a_req.addr] <= i_a_req.din;
    end
  end

  // Port B, read-first
  always @(posedge clk) begin
    o_b_dout <= mem[i_b_req.addr];
    if (i_b_req.we) begin
      mem[i_b_req.addr] <= i_b_req.din;
    end
  end

  // User port and sequencer must never collide on a write
  assert property (@(posedge clk)
    !(i_a_req.we && i_b_req.we && (i_a_req.addr == i_b_req.addr)))
    else $error("dual_port_buffer: both ports write address %0h", i_a_req.addr);

endmodule

/* logic/bram_valid_tracker.sv */
`timescale 1ns/1ps

module bram_valid_tracker
  import dpb_adapter_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  mem_addr_t i_addr,
  output logic      o_valid
);

  mem_addr_t   prev_addr;
  wait_count_t wait_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_addr <= '0;
      wait_cnt  <= wait_count_t'(MEM_WAIT);
    end else if (i_addr != prev_addr) begin
      // New address, restart the settle count
      prev_addr <= i_addr;
      wait_cnt  <= '0;
    end else if (wait_cnt < wait_count_t'(MEM_WAIT)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Drops as soon as the address moves away from the captured one
  assign o_valid = (prev_addr == i_addr) && (wait_cnt == wait_count_t'(MEM_WAIT));

  // Valid data implies the address has been held across the settle window
  assert property (@(posedge clk) disable iff (rst)
    o_valid |-> (i_addr == $past(i_addr)) && (i_addr == $past(i_addr, MEM_WAIT)))
    else $error("bram_valid_tracker: valid raised on an unsettled address");

endmodule

/* logic/ping_pong_fifo.sv */
`timescale 1ns/1ps

module ping_pong_fifo
  import dpb_adapter_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic [1:0] o_wr_ready,
  input  pp_wr_req_t i_wr_req,
  input  pp_rd_req_t i_rd_req,
  output pp_rd_rsp_t o_rd_rsp
);

  typedef enum logic [1:0] {
    BANK_EMPTY,
    BANK_WRITING,
    BANK_FULL,
    BANK_READING
  } bank_state_t;

  bank_state_t bank_state [2];
  pp_count_t   fill [2];
  word_t       bank_mem [2][PP_DEPTH];

  logic       rd_sel;
  logic       rd_bank;
  logic       rd_active;
  pp_count_t  rd_ptr;
  logic       rd_ready;
  logic       rd_start;
  logic [1:0] wr_open;
  logic       wr_bank;
  logic       wr_fire;

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wr_ready[b] = (bank_state[b] == BANK_EMPTY);
      wr_open[b]    = i_wr_req.activate[b] &&
                      ((bank_state[b] == BANK_EMPTY) || (bank_state[b] == BANK_WRITING));
    end
  end

  assign wr_bank = i_wr_req.activate[1];
  assign wr_fire = i_wr_req.stb && wr_open[wr_bank] &&
                   (fill[wr_bank] < pp_count_t'(PP_DEPTH));

  // rd_sel always points at the older committed bank
  assign rd_ready = (bank_state[rd_sel] == BANK_FULL) && !rd_active;
  assign rd_start = i_rd_req.activate && rd_ready;

  assign o_rd_rsp.ready = rd_ready;
  assign o_rd_rsp.size  = rd_active ? fill[rd_bank] : '0;
  assign o_rd_rsp.data  = bank_mem[rd_bank][rd_ptr[PP_ADDR_WIDTH-1:0]];

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bank_mem[wr_bank][fill[wr_bank][PP_ADDR_WIDTH-1:0]] <= i_wr_req.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        bank_state[b] <= BANK_EMPTY;
        fill[b]       <= '0;
      end
      rd_sel    <= 1'b0;
      rd_bank   <= 1'b0;
      rd_active <= 1'b0;
      rd_ptr    <= '0;
    end else begin
      // Write side, one bank at a time
      for (int b = 0; b < 2; b++) begin
        if (wr_open[b]) begin
          bank_state[b] <= BANK_WRITING;
          if (wr_fire && (wr_bank == 1'(b))) begin
            fill[b] <= fill[b] + 1'b1;
          end
        end else if (bank_state[b] == BANK_WRITING) begin
          if (fill[b] != '0) begin
            bank_state[b] <= BANK_FULL;
            // First in line if the other bank is not already waiting
            if (bank_state[1-b] != BANK_FULL) begin
              rd_sel <= 1'(b);
            end
          end else begin
            bank_state[b] <= BANK_EMPTY;
          end
        end
      end

      // Read side
      if (rd_start) begin
        bank_state[rd_sel] <= BANK_READING;
        rd_bank            <= rd_sel;
        rd_active          <= 1'b1;
        rd_ptr             <= '0;
        rd_sel             <= ~rd_sel;
      end else if (rd_active) begin
        if (!i_rd_req.activate) begin
          // Reader done, bank goes back to the writer
          bank_state[rd_bank] <= BANK_EMPTY;
          fill[rd_bank]       <= '0;
          rd_active           <= 1'b0;
        end else if (i_rd_req.stb) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    i_wr_req.stb |-> (i_wr_req.activate != 2'b00))
    else $error("ping_pong_fifo: write strobe without an active bank");

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(i_wr_req.activate))
    else $error("ping_pong_fifo: both write banks activated");

  for (genvar g = 0; g < 2; g++) begin : g_wr_claim
    assert property (@(posedge clk) disable iff (rst)
      $rose(i_wr_req.activate[g]) |-> o_wr_ready[g])
      else $error("ping_pong_fifo: bank %0d claimed while not ready", g);
  end

  assert property (@(posedge clk) disable iff (rst)
    i_rd_req.stb |-> rd_active && (rd_ptr < fill[rd_bank]))
    else $error("ping_pong_fifo: read strobe past the bank size");

endmodule

/* logic/ppfifo_mem_sequencer.sv */
`timescale 1ns/1ps

module ppfifo_mem_sequencer
  import dpb_adapter_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_drain_en,
  input  logic        i_load_stb,
  input  logic        i_cancel_stb,
  output logic        o_idle,
  output read_count_t o_num_reads,
  input  pp_rd_rsp_t  i_src_rsp,
  output pp_rd_req_t  o_src_req,
  input  logic [1:0]  i_dst_ready,
  output pp_wr_req_t  o_dst_req,
  output bram_req_t   o_mem_req,
  input  word_t       i_mem_dout
);

  seq_state_t state;
  pp_count_t  count;
  mem_addr_t  mem_addr;
  logic       src_act;
  logic       src_live;
  logic [1:0] dst_act;
  logic       dst_stb;
  logic       drain_word;
  logic       load_word;

  // Ingress size and data are only meaningful once the FIFO has granted the bank
  assign drain_word = (state == SEQ_DRAIN) && src_live && (count < i_src_rsp.size);
  assign load_word  = (state == SEQ_LOAD) && (count < pp_count_t'(PP_DEPTH));

  assign o_idle = (state == SEQ_IDLE);

  assign o_src_req.activate = src_act;
  assign o_src_req.stb      = drain_word;

  assign o_mem_req.we   = drain_word;
  assign o_mem_req.addr = mem_addr;
  assign o_mem_req.din  = i_src_rsp.data;

  // Port B read data lands one cycle after its address
  assign o_dst_req.activate = dst_act;
  assign o_dst_req.stb      = dst_stb;
  assign o_dst_req.data     = i_mem_dout;

  always_ff @(posedge clk) begin
    if (rst || i_cancel_stb) begin
      state       <= SEQ_IDLE;
      count       <= '0;
      mem_addr    <= '0;
      src_act     <= 1'b0;
      src_live    <= 1'b0;
      dst_act     <= 2'b00;
      dst_stb     <= 1'b0;
      o_num_reads <= '0;
    end else begin
      dst_stb <= load_word;
      case (state)
        SEQ_IDLE: begin
          count    <= '0;
          mem_addr <= '0;
          src_live <= 1'b0;
          // Load wins over drain
          if (i_load_stb) begin
            state <= SEQ_LOAD_SETUP;
          end else if (i_drain_en && i_src_rsp.ready) begin
            src_act <= 1'b1;
            state   <= SEQ_DRAIN;
          end
        end

        SEQ_DRAIN: begin
          src_live <= 1'b1;
          if (drain_word) begin
            count       <= count + 1'b1;
            mem_addr    <= mem_addr + 1'b1;
            o_num_reads <= o_num_reads + 1'b1;
          end else if (src_live) begin
            // Hand the emptied bank back
            src_act <= 1'b0;
            state   <= SEQ_IDLE;
          end
        end

        SEQ_LOAD_SETUP: begin
          count    <= '0;
          mem_addr <= '0;
          if (i_dst_ready[0]) begin
            dst_act <= 2'b01;
            state   <= SEQ_LOAD;
          end else if (i_dst_ready[1]) begin
            dst_act <= 2'b10;
            state   <= SEQ_LOAD;
          end
        end

        SEQ_LOAD: begin
          if (load_word) begin
            count    <= count + 1'b1;
            mem_addr <= mem_addr + 1'b1;
          end else if (count == pp_count_t'(PP_DEPTH)) begin
            // Last strobe is out this cycle
            dst_act <= 2'b00;
            count   <= count + 1'b1;
          end else begin
            // One extra cycle so the egress bank is committed before idle
            state <= SEQ_IDLE;
          end
        end

        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Every egress strobe goes to exactly one active bank
  assert property (@(posedge clk) disable iff (rst)
    o_dst_req.stb |-> $onehot(o_dst_req.activate))
    else $error("ppfifo_mem_sequencer: egress strobe without a one-hot activate");

  // Buffer writes stay inside a drain and below the granted ingress bank size
  assert property (@(posedge clk) disable iff (rst)
    o_mem_req.we |-> (state == SEQ_DRAIN) &&
                     (o_mem_req.addr < mem_addr_t'(i_src_rsp.size)))
    else $error("ppfifo_mem_sequencer: buffer write outside a drain");

endmodule

/* logic/dpb_ppfifo_top.sv */
`timescale 1ns/1ps

module dpb_ppfifo_top
  import dpb_adapter_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // Ingress FIFO, writer side
  output logic [1:0]  o_in_ready,
  input  pp_wr_req_t  i_in_req,

  // Egress FIFO, reader side
  input  pp_rd_req_t  i_out_req,
  output pp_rd_rsp_t  o_out_rsp,

  // User memory port
  input  bram_req_t   i_bram_req,
  output word_t       o_bram_dout,
  output logic        o_bram_valid,

  // Transfer control
  input  logic        i_drain_en,
  input  logic        i_load_stb,
  input  logic        i_cancel_stb,
  output logic        o_idle,
  output read_count_t o_num_reads
);

  pp_rd_req_t src_req;
  pp_rd_rsp_t src_rsp;
  logic [1:0] dst_ready;
  pp_wr_req_t dst_req;
  bram_req_t  mem_b_req;
  word_t      mem_b_dout;

  dual_port_buffer buffer_i (
    .clk      (clk),
    .i_a_req  (i_bram_req),
    .o_a_dout (o_bram_dout),
    .i_b_req  (mem_b_req),
    .o_b_dout (mem_b_dout)
  );

  bram_valid_tracker valid_i (
    .clk     (clk),
    .rst     (rst),
    .i_addr  (i_bram_req.addr),
    .o_valid (o_bram_valid)
  );

  ping_pong_fifo ingress_fifo (
    .clk        (clk),
    .rst        (rst),
    .o_wr_ready (o_in_ready),
    .i_wr_req   (i_in_req),
    .i_rd_req   (src_req),
    .o_rd_rsp   (src_rsp)
  );

  ping_pong_fifo egress_fifo (
    .clk        (clk),
    .rst        (rst),
    .o_wr_ready (dst_ready),
    .i_wr_req   (dst_req),
    .i_rd_req   (i_out_req),
    .o_rd_rsp   (o_out_rsp)
  );

  ppfifo_mem_sequencer seq_i (
    .clk          (clk),
    .rst          (rst),
    .i_drain_en   (i_drain_en),
    .i_load_stb   (i_load_stb),
    .i_cancel_stb (i_cancel_stb),
    .o_idle       (o_idle),
    .o_num_reads  (o_num_reads),
    .i_src_rsp    (src_rsp),
    .o_src_req    (src_req),
    .i_dst_ready  (dst_ready),
    .o_dst_req    (dst_req),
    .o_mem_req    (mem_b_req),
    .i_mem_dout   (mem_b_dout)
  );

endmodule

/* testbench/tb_dpb_ppfifo.sv */
`timescale 1ns/1ps

module tb_dpb_ppfifo
  import dpb_adapter_pkg::*;
;

  localparam int CLK_PERIOD = 8;
  localparam int WAIT_LIMIT = 100;
  localparam int FLAG_IDLE = 0;
  localparam int FLAG_VALID = 1;
  localparam int FLAG_IN_READY = 2;
  localparam int FLAG_OUT_READY = 3;

  logic        clk = 1'b0;
  logic        rst;
  logic [1:0]  in_ready;
  pp_wr_req_t  in_req;
  pp_rd_req_t  out_req;
  pp_rd_rsp_t  out_rsp;
  bram_req_t   bram_req;
  word_t       bram_dout;
  logic        bram_valid;
  logic        drain_en;
  logic        load_stb;
  logic        cancel_stb;
  logic        idle;
  read_count_t num_reads;

  // Reference copy of the buffer and the banks still waiting in the ingress
  word_t       model [0:(2**MEM_DEPTH)-1];
  word_t       bank_words [$];
  int          bank_len [$];
  logic [31:0] rng = 32'd14239;
  int          num_lines = 0;

  dpb_ppfifo_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .o_in_ready   (in_ready),
    .i_in_req     (in_req),
    .i_out_req    (out_req),
    .o_out_rsp    (out_rsp),
    .i_bram_req   (bram_req),
    .o_bram_dout  (bram_dout),
    .o_bram_valid (bram_valid),
    .i_drain_en   (drain_en),
    .i_load_stb   (load_stb),
    .i_cancel_stb (cancel_stb),
    .o_idle       (idle),
    .o_num_reads  (num_reads)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic flag_value(input int sel);
    case (sel)
      FLAG_IDLE:     return idle;
      FLAG_VALID:    return bram_valid;
      FLAG_IN_READY: return |in_ready;
      default:       return out_rsp.ready;
    endcase
  endfunction

  // Sample and drive point, just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic wait_for_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (flag_value(sel) !== level) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("Simulation failed");
        $fatal(1);
      end
      cycles++;
      next_cycle();
    end
  endtask

  task automatic user_write(input mem_addr_t addr, input word_t data);
    bram_req.we   = 1'b1;
    bram_req.addr = addr;
    bram_req.din  = data;
    model[addr]   = data;
    next_cycle();
    bram_req.we = 1'b0;
    // Let the registered read pick up the new word
    next_cycle();
  endtask

  task automatic user_read(input mem_addr_t addr, input word_t expected);
    logic moved;
    moved = (addr != bram_req.addr);
    bram_req.we   = 1'b0;
    bram_req.addr = addr;
    next_cycle();
    if (moved) begin
      check_equal(bram_valid, 1'b0, "valid after address change");
    end
    wait_for_level(FLAG_VALID, 1'b1, "user read valid");
    check_equal(bram_dout, expected, "user read data");
  endtask

  task automatic push_words(input int n);
    int i;
    wait_for_level(FLAG_IN_READY, 1'b1, "ingress ready");
    // Bank 0 has priority when both are free
    in_req.activate = in_ready[0] ? 2'b01 : 2'b10;
    for (i = 0; i < n; i++) begin
      rng = xorshift(rng);
      in_req.stb  = 1'b1;
      in_req.data = rng;
      bank_words.push_back(rng);
      next_cycle();
    end
    in_req = '0;
    next_cycle();
    bank_len.push_back(n);
  endtask

  task automatic drain_banks();
    int len;
    int i;
    drain_en = 1'b1;
    while (bank_len.size() > 0) begin
      len = bank_len.pop_front();
      wait_for_level(FLAG_IDLE, 1'b0, "drain start");
      wait_for_level(FLAG_IDLE, 1'b1, "drain end");
      for (i = 0; i < len; i++) begin
        model[i] = bank_words.pop_front();
      end
    end
    drain_en = 1'b0;
    next_cycle();
  endtask

  task automatic load_and_read();
    int k;
    load_stb = 1'b1;
    next_cycle();
    load_stb = 1'b0;
    wait_for_level(FLAG_IDLE, 1'b1, "load end");
    wait_for_level(FLAG_OUT_READY, 1'b1, "egress ready");
    out_req.activate = 1'b1;
    next_cycle();
    check_equal(out_rsp.size, PP_DEPTH, "egress bank size");
    for (k = 0; k < PP_DEPTH; k++) begin
      check_equal(out_rsp.data, model[k], "egress word");
      out_req.stb = 1'b1;
      next_cycle();
    end
    out_req = '0;
    next_cycle();
  endtask

  task automatic cancel_transfer();
    cancel_stb = 1'b1;
    next_cycle();
    cancel_stb = 1'b0;
    check_equal(idle, 1'b1, "idle after cancel");
  endtask

  // Watchdog sized from the stimulus length
  initial begin
    wait (num_lines > 0);
    repeat (num_lines * 200 + 32) @(posedge clk);
    $display("Watchdog expired before the stimulus file was finished");
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    int fd;
    int code;
    logic done;
    logic [8*256-1:0] line;
    logic [8*8-1:0]   cmd;
    logic [8*16-1:0]  tok;
    mem_addr_t        addr_v;
    logic [31:0]      val;

    rst        = 1'b1;
    in_req     = '0;
    out_req    = '0;
    bram_req   = '0;
    drain_en   = 1'b0;
    load_stb   = 1'b0;
    cancel_stb = 1'b0;

    fd = $fopen("testbench/dpb_ppfifo_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0) begin
        num_lines++;
      end
    end
    $fclose(fd);
    fd = $fopen("testbench/dpb_ppfifo_stimulus.txt", "r");

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    check_equal(idle, 1'b1, "idle after reset");
    check_equal(num_reads, 32'd0, "read count after reset");
    check_equal(in_ready, 2'b11, "ingress ready after reset");
    check_equal(out_rsp.ready, 1'b0, "egress ready after reset");

    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", addr_v, val);
            user_write(addr_v, val);
          end
          "R": begin
            code = $fscanf(fd, "%h %s", addr_v, tok);
            // m takes the expected word from the model
            if (tok == "m") begin
              val = model[addr_v];
            end else begin
              code = $sscanf(tok, "%h", val);
            end
            user_read(addr_v, val);
          end
          "I": begin
            code = $fscanf(fd, "%h", val);
            push_words(val);
          end
          "D": drain_banks();
          "L": load_and_read();
          "C": cancel_transfer();
          "N": begin
            code = $fscanf(fd, "%h", val);
            check_equal(num_reads, val, "read count");
          end
          default: begin
            $display("Unknown command %0s in the stimulus file", cmd);
            $display("Simulation failed");
            $fatal(1);
          end
        endcase
      end
    end
    $fclose(fd);

    $display("Simulation passed");
    $finish;
  end

endmodule

/* testbench/dpb_ppfifo_stimulus.txt */
# cmd operands, all numbers hex: W addr data | R addr expected or m for the model
# I word count | D drain | L load and read | C cancel | N expected read count
W 010 cafe0001
W 011 cafe0002
R 010 cafe0001
R 011 cafe0002
W 010 0badf00d
R 011 cafe0002
R 010 0badf00d
N 0
I 5
D
R 000 m
R 002 m
R 004 m
N 5
I c
I 7
D
R 000 m
R 006 m
R 007 m
R 00b m
N 18
W 000 10000000
W 001 10000011
W 002 10000022
W 003 10000033
W 004 10000044
W 005 10000055
W 006 10000066
W 007 10000077
W 008 10000088
W 009 10000099
W 00a 100000aa
W 00b 100000bb
W 00c 100000cc
W 00d 100000dd
W 00e 100000ee
W 00f 100000ff
L
C
N 0
I 3
D
R 000 m
R 001 m
R 002 m
N 3

/* tb.f */
logic/dpb_adapter_pkg.sv
logic/dual_port_buffer.sv
logic/bram_valid_tracker.sv
logic/ping_pong_fifo.sv
logic/ppfifo_mem_sequencer.sv
logic/dpb_ppfifo_top.sv
testbench/tb_dpb_ppfifo.sv

/* Bender.yml */
package:
  name: dpb_ppfifo

sources:
  - logic/dpb_adapter_pkg.sv
  - logic/dual_port_buffer.sv
  - logic/bram_valid_tracker.sv
  - logic/ping_pong_fifo.sv
  - logic/ppfifo_mem_sequencer.sv
  - logic/dpb_ppfifo_top.sv
  - target: simulation
    files:
      - testbench/tb_dpb_ppfifo.sv
